//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tbElevator \
		-f tb.f -Mdir obj_dir
	./obj_dir/VtbElevator > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then \
		exit 1; \
	elif ! grep -q "TB PASSED" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hw/callPanel.sv
`timescale 1ns/100ps

module callPanel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       update,
    input  logic [elevatorPkg::FLOOR_W-1:0] hallFloor,
    input  logic                       hallUp,
    input  logic                       hallDown,
    input  elevatorPkg::floorMaskT     carSwitches,
    output elevatorPkg::floorMaskT     setHallUp,
    output elevatorPkg::floorMaskT     setHallDown,
    output elevatorPkg::floorMaskT     setCar
);
    import elevatorPkg::*;

    // Switch levels seen at the previous update
    floorMaskT lastSwitches;
    // One-hot hall floor, empty for floors above the top
    floorMaskT hallOneHot;

    always_comb
    begin
        for (int i = 0; i < NUM_FLOORS; i++)
        begin
            hallOneHot[i] = (hallFloor == FLOOR_W'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            setHallUp    <= '0;
            setHallDown  <= '0;
            setCar       <= '0;
            lastSwitches <= '0;
        end
        else
        begin
            // Masks last exactly one cycle
            setHallUp   <= '0;
            setHallDown <= '0;
            setCar      <= '0;
            if (update)
            begin
                // Up button has priority over down
                if (hallUp)
                begin
                    setHallUp <= hallOneHot;
                end
                else if (hallDown)
                begin
                    setHallDown <= hallOneHot;
                end
                // Only switches that went from off to on call the car
                setCar       <= carSwitches & ~lastSwitches;
                lastSwitches <= carSwitches;
            end
        end
    end

    // No set mask without an update strobe one cycle earlier
    apNoSetWithoutUpdate : assert property (@(posedge clk) disable iff (rst)
        !update |=> (setHallUp == '0) && (setHallDown == '0) && (setCar == '0));

endmodule

//--- hw/carController.sv
`timescale 1ns/100ps

module carController (
    input  logic                   clk,
    input  logic                   rst,
    input  elevatorPkg::floorMaskT pendHallUp,
    input  elevatorPkg::floorMaskT pendHallDown,
    input  elevatorPkg::floorMaskT pendCar,
    output elevatorPkg::floorMaskT clearMask,
    output elevatorPkg::dirT       direction,
    output logic [6:0]             segments
);
    import elevatorPkg::*;

    carStateT state;
    logic [FLOOR_W-1:0] curFloor;
    logic [FLOOR_W-1:0] target;
    // Shared by travel and dwell timing
    logic [$clog2(DWELL_CYCLES)-1:0] cnt;
    // Direction of the move that led into a dwell
    dirT keptDir;

    floorMaskT allReq;
    floorMaskT reqAbove;
    floorMaskT reqBelow;
    floorMaskT beyondUp;
    floorMaskT beyondDown;
    logic [FLOOR_W-1:0] nearUp;
    logic [FLOOR_W-1:0] nearDown;
    logic [FLOOR_W-1:0] farUp;
    logic [FLOOR_W-1:0] farDown;
    logic [FLOOR_W-1:0] nextFloor;
    logic goUp;
    logic stopHere;
    logic travelDone;
    logic dwellDone;

    //////////////////////////////////////////////////
    // Request masks around the car
    //////////////////////////////////////////////////

    always_comb
    begin
        allReq = pendHallUp | pendHallDown | pendCar;
        for (int i = 0; i < NUM_FLOORS; i++)
        begin
            reqAbove[i]   = allReq[i] && (i > int'(curFloor));
            reqBelow[i]   = allReq[i] && (i < int'(curFloor));
            // Beyond the floor about to be reached
            beyondUp[i]   = allReq[i] && (i > int'(curFloor) + 1);
            beyondDown[i] = allReq[i] && (i < int'(curFloor) - 1);
        end
    end

    // Nearest and farthest requests on each side
    always_comb
    begin
        nearUp   = curFloor;
        farUp    = curFloor;
        nearDown = curFloor;
        farDown  = curFloor;
        // Downward scan keeps the lowest hit
        for (int i = TOP_FLOOR; i >= 0; i--)
        begin
            if (reqAbove[i])
                nearUp = FLOOR_W'(i);
            if (reqBelow[i])
                farDown = FLOOR_W'(i);
        end
        // Upward scan keeps the highest hit
        for (int i = 0; i < NUM_FLOORS; i++)
        begin
            if (reqAbove[i])
                farUp = FLOOR_W'(i);
            if (reqBelow[i])
                nearDown = FLOOR_W'(i);
        end
    end

    // Tie between the two sides goes up
    assign goUp = (reqAbove != '0) &&
                  ((reqBelow == '0) || ((nearUp - curFloor) <= (curFloor - nearDown)));

    assign nextFloor  = (state == MOVE_DOWN) ? curFloor - 1'b1 : curFloor + 1'b1;
    assign travelDone = (cnt == TRAVEL_CYCLES - 1);
    assign dwellDone  = (state == DWELL) && (cnt == DWELL_CYCLES - 1);

    // Stop rule on arrival at nextFloor
    always_comb
    begin
        if (state == MOVE_UP)
            stopHere = pendCar[nextFloor] || pendHallUp[nextFloor] ||
                       (nextFloor == target) || (beyondUp == '0);
        else
            stopHere = pendCar[nextFloor] || pendHallDown[nextFloor] ||
                       (nextFloor == target) || (beyondDown == '0);
    end

    //////////////////////////////////////////////////
    // Car FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= IDLE;
            curFloor <= FLOOR_W'(RESET_FLOOR);
            target   <= FLOOR_W'(RESET_FLOOR);
            cnt      <= '0;
            keptDir  <= DIR_IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    cnt <= '0;
                    // Someone waiting right here opens the doors
                    if (allReq[curFloor])
                    begin
                        state   <= DWELL;
                        keptDir <= DIR_IDLE;
                    end
                    else if (goUp)
                    begin
                        state   <= MOVE_UP;
                        target  <= nearUp;
                        keptDir <= DIR_UP;
                    end
                    else if (reqBelow != '0)
                    begin
                        state   <= MOVE_DOWN;
                        target  <= nearDown;
                        keptDir <= DIR_DOWN;
                    end
                end
                MOVE_UP, MOVE_DOWN:
                begin
                    if (travelDone)
                    begin
                        cnt      <= '0;
                        curFloor <= nextFloor;
                        if (stopHere)
                            state <= DWELL;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                DWELL:
                begin
                    if (dwellDone)
                    begin
                        cnt <= '0;
                        // Keep going the same way while work remains there
                        if ((keptDir == DIR_UP) && (reqAbove != '0))
                        begin
                            state  <= MOVE_UP;
                            target <= farUp;
                        end
                        else if ((keptDir == DIR_DOWN) && (reqBelow != '0))
                        begin
                            state  <= MOVE_DOWN;
                            target <= farDown;
                        end
                        else
                            state <= IDLE;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Release every call at this floor as the doors close
    always_comb
    begin
        clearMask = '0;
        if (dwellDone)
            clearMask[curFloor] = 1'b1;
    end

    always_comb
    begin
        case (state)
            MOVE_UP:   direction = DIR_UP;
            MOVE_DOWN: direction = DIR_DOWN;
            DWELL:     direction = keptDir;
            default:   direction = DIR_IDLE;
        endcase
    end

    assign segments = segPattern(curFloor);

    // Car never leaves the shaft
    apFloorRange : assert property (@(posedge clk) disable iff (rst)
        curFloor <= FLOOR_W'(TOP_FLOOR));

    // A downward run never begins on the ground floor
    apNoDownFromZero : assert property (@(posedge clk) disable iff (rst)
        (state != MOVE_DOWN) ##1 (state == MOVE_DOWN) |-> (curFloor != '0));

    apDirLegal : assert property (@(posedge clk) disable iff (rst)
        direction inside {DIR_DOWN, DIR_UP, DIR_IDLE});

endmodule

//--- hw/elevatorPkg.sv
package elevatorPkg;

    //////////////////////////////////////////////////
    // Building geometry
    //////////////////////////////////////////////////

    localparam int NUM_FLOORS  = 5;
    localparam int TOP_FLOOR   = NUM_FLOORS - 1;
    localparam int FLOOR_W     = 3;
    // Car parks here after reset
    localparam int RESET_FLOOR = 1;

    // Cycles per floor of travel and cycles with the doors open
    localparam int TRAVEL_CYCLES = 6;
    localparam int DWELL_CYCLES  = 10;

    // One request bit per floor
    typedef logic [NUM_FLOORS-1:0] floorMaskT;

    // Direction lamp encoding
    typedef enum logic [1:0] {
        DIR_DOWN = 2'b00,
        DIR_UP   = 2'b01,
        DIR_IDLE = 2'b11
    } dirT;

    // Car FSM states
    typedef enum logic [1:0] {
        IDLE,
        MOVE_UP,
        MOVE_DOWN,
        DWELL
    } carStateT;

    // Active-low seven-segment digit for a floor, blank when out of range
    function automatic logic [6:0] segPattern(input logic [FLOOR_W-1:0] floorIdx);
        logic [6:0] pattern;
        case (floorIdx)
            FLOOR_W'(0): pattern = 7'b0000001;
            FLOOR_W'(1): pattern = 7'b1001111;
            FLOOR_W'(2): pattern = 7'b0010010;
            FLOOR_W'(3): pattern = 7'b0000110;
            FLOOR_W'(4): pattern = 7'b1001100;
            default:     pattern = 7'b1111111;
        endcase
        return pattern;
    endfunction

endpackage

//--- hw/elevatorTop.sv
`timescale 1ns/100ps

module elevatorTop (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       update,
    input  logic [elevatorPkg::FLOOR_W-1:0] hallFloor,
    input  logic                       hallUp,
    input  logic                       hallDown,
    input  elevatorPkg::floorMaskT     carSwitches,
    output elevatorPkg::dirT           direction,
    output logic [6:0]                 segments
);
    import elevatorPkg::*;

    //////////////////////////////////////////////////
    // Call path, panel to store to controller
    //////////////////////////////////////////////////

    floorMaskT setHallUp;
    floorMaskT setHallDown;
    floorMaskT setCar;
    floorMaskT pendHallUp;
    floorMaskT pendHallDown;
    floorMaskT pendCar;
    // Fed back from the controller at the end of each dwell
    floorMaskT clearMask;

    callPanel i_callPanel (
        .clk, .rst, .update, .hallFloor, .hallUp, .hallDown, .carSwitches,
        .setHallUp, .setHallDown, .setCar
    );

    requestStore i_requestStore (
        .clk, .rst, .setHallUp, .setHallDown, .setCar, .clearMask,
        .pendHallUp, .pendHallDown, .pendCar
    );

    carController i_carController (
        .clk, .rst, .pendHallUp, .pendHallDown, .pendCar,
        .clearMask, .direction, .segments
    );

endmodule

//--- hw/requestStore.sv
`timescale 1ns/100ps

module requestStore (
    input  logic                   clk,
    input  logic                   rst,
    input  elevatorPkg::floorMaskT setHallUp,
    input  elevatorPkg::floorMaskT setHallDown,
    input  elevatorPkg::floorMaskT setCar,
    input  elevatorPkg::floorMaskT clearMask,
    output elevatorPkg::floorMaskT pendHallUp,
    output elevatorPkg::floorMaskT pendHallDown,
    output elevatorPkg::floorMaskT pendCar
);

    //////////////////////////////////////////////////
    // Pending request vectors
    //////////////////////////////////////////////////

    // Three independent vectors share one clear mask
    // Clear first, then set, so a call made during the
    // closing cycle of a dwell is not lost

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pendHallUp   <= '0;
            pendHallDown <= '0;
            pendCar      <= '0;
        end
        else
        begin
            // Hall calls wanting to go up
            pendHallUp   <= (pendHallUp & ~clearMask) | setHallUp;

            // Hall calls wanting to go down
            pendHallDown <= (pendHallDown & ~clearMask) | setHallDown;

            // Calls from the car switches
            pendCar      <= (pendCar & ~clearMask) | setCar;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Controller only ever releases the floor it stands at
    apClearOneFloor : assert property (@(posedge clk) disable iff (rst)
        $onehot0(clearMask));

endmodule

//--- tb.f
hw/elevatorPkg.sv
hw/callPanel.sv
hw/requestStore.sv
hw/carController.sv
hw/elevatorTop.sv
test/tbElevator.sv

//--- test/tbElevator.sv
`timescale 1ns/100ps

module tbElevator;
    import elevatorPkg::*;

    //////////////////////////////////////////////////
    // Run length and model state codes
    //////////////////////////////////////////////////

    localparam int RAND_CYCLES = 3000;
    // Directed part plus random part, in clock cycles
    localparam int STIM_CYCLES = RAND_CYCLES + 1000;
    // Longest trip across the shaft with one stop
    localparam int TRIP_CYCLES = TRAVEL_CYCLES * TOP_FLOOR + DWELL_CYCLES;
    localparam int S_IDLE  = 0;
    localparam int S_UP    = 1;
    localparam int S_DOWN  = 2;
    localparam int S_DWELL = 3;

    logic clk;
    logic rst;
    logic update;
    logic [FLOOR_W-1:0] hallFloor;
    logic hallUp;
    logic hallDown;
    floorMaskT carSwitches;
    dirT direction;
    logic [6:0] segments;

    logic [31:0] lfsr;
    int checks;
    int errors;
    int lat;

    // Model of the call path
    floorMaskT mLastSw;
    floorMaskT mSetUp;
    floorMaskT mSetDn;
    floorMaskT mSetCar;
    floorMaskT mPendUp;
    floorMaskT mPendDn;
    floorMaskT mPendCar;
    // Model of the car
    int mState;
    int mFloor;
    int mTarget;
    int mCnt;
    dirT mKept;

    elevatorTop i_dut (
        .clk, .rst, .update, .hallFloor, .hallUp, .hallDown, .carSwitches,
        .direction, .segments
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Random source and expected outputs
    //////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsrStep());
        return v;
    endfunction

    // Active-low digit table for floors 0 to 4
    function automatic int expSegments(input int fl);
        int pat;
        case (fl)
            0:       pat = 7'b0000001;
            1:       pat = 7'b1001111;
            2:       pat = 7'b0010010;
            3:       pat = 7'b0000110;
            4:       pat = 7'b1001100;
            default: pat = 7'b1111111;
        endcase
        return pat;
    endfunction

    function automatic dirT expDirection();
        dirT d;
        case (mState)
            S_UP:    d = DIR_UP;
            S_DOWN:  d = DIR_DOWN;
            S_DWELL: d = mKept;
            default: d = DIR_IDLE;
        endcase
        return d;
    endfunction

    // Nothing in flight and the car parked
    function automatic logic modelQuiet();
        return (mState == S_IDLE) && ((mSetUp | mSetDn | mSetCar) == '0) &&
               ((mPendUp | mPendDn | mPendCar) == '0);
    endfunction

    task automatic check(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model, one clock edge per call
    //////////////////////////////////////////////////

    task automatic stepModel();
        floorMaskT allReq;
        floorMaskT above;
        floorMaskT below;
        floorMaskT clr;
        floorMaskT hot;
        int nearUp;
        int nearDn;
        int farUp;
        int farDn;
        int nxt;
        bit beyond;
        bit stop;
        if (rst)
        begin
            mLastSw  = '0;
            mSetUp   = '0;
            mSetDn   = '0;
            mSetCar  = '0;
            mPendUp  = '0;
            mPendDn  = '0;
            mPendCar = '0;
            mState   = S_IDLE;
            mFloor   = RESET_FLOOR;
            mTarget  = RESET_FLOOR;
            mCnt     = 0;
            mKept    = DIR_IDLE;
        end
        else
        begin
            allReq = mPendUp | mPendDn | mPendCar;
            nearUp = mFloor;
            farUp  = mFloor;
            nearDn = mFloor;
            farDn  = mFloor;
            // Scan from the ground floor upward
            for (int i = 0; i < NUM_FLOORS; i++)
            begin
                above[i] = allReq[i] && (i > mFloor);
                below[i] = allReq[i] && (i < mFloor);
                if (above[i] && (nearUp == mFloor))
                    nearUp = i;
                if (above[i])
                    farUp = i;
                if (below[i] && (farDn == mFloor))
                    farDn = i;
                if (below[i])
                    nearDn = i;
            end
            clr = '0;
            case (mState)
                S_IDLE:
                begin
                    mCnt = 0;
                    if (allReq[mFloor])
                    begin
                        mState = S_DWELL;
                        mKept  = DIR_IDLE;
                    end
                    // Equal distance prefers up
                    else if ((above != '0) &&
                             ((below == '0) || (nearUp - mFloor <= mFloor - nearDn)))
                    begin
                        mState  = S_UP;
                        mTarget = nearUp;
                        mKept   = DIR_UP;
                    end
                    else if (below != '0)
                    begin
                        mState  = S_DOWN;
                        mTarget = nearDn;
                        mKept   = DIR_DOWN;
                    end
                end
                S_UP, S_DOWN:
                begin
                    if (mCnt == TRAVEL_CYCLES - 1)
                    begin
                        nxt    = (mState == S_UP) ? mFloor + 1 : mFloor - 1;
                        beyond = 1'b0;
                        for (int j = 0; j < NUM_FLOORS; j++)
                        begin
                            if (allReq[j] && ((mState == S_UP) ? (j > nxt) : (j < nxt)))
                                beyond = 1'b1;
                        end
                        // Car call, matching hall call, target or end of the run
                        stop = mPendCar[nxt] || (nxt == mTarget) || !beyond ||
                               ((mState == S_UP) ? mPendUp[nxt] : mPendDn[nxt]);
                        mFloor = nxt;
                        mCnt   = 0;
                        if (stop)
                            mState = S_DWELL;
                    end
                    else
                        mCnt++;
                end
                default:
                begin
                    if (mCnt == DWELL_CYCLES - 1)
                    begin
                        clr[mFloor] = 1'b1;
                        mCnt = 0;
                        if ((mKept == DIR_UP) && (above != '0))
                        begin
                            mState  = S_UP;
                            mTarget = farUp;
                        end
                        else if ((mKept == DIR_DOWN) && (below != '0))
                        begin
                            mState  = S_DOWN;
                            mTarget = farDn;
                        end
                        else
                            mState = S_IDLE;
                    end
                    else
                        mCnt++;
                end
            endcase
            // A new call beats the clear
            mPendUp  = (mPendUp & ~clr) | mSetUp;
            mPendDn  = (mPendDn & ~clr) | mSetDn;
            mPendCar = (mPendCar & ~clr) | mSetCar;
            mSetUp   = '0;
            mSetDn   = '0;
            mSetCar  = '0;
            if (update)
            begin
                hot = '0;
                if (hallFloor <= TOP_FLOOR)
                    hot[int'(hallFloor)] = 1'b1;
                if (hallUp)
                    mSetUp = hot;
                else if (hallDown)
                    mSetDn = hot;
                mSetCar = carSwitches & ~mLastSw;
                mLastSw = carSwitches;
            end
        end
    endtask

    // Compare against state after the last edge, then advance to the next one
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check("direction", direction, expDirection());
            check("segments", segments, expSegments(mFloor));
        end
        stepModel();
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic pulseUpdate(input int fl, input bit up, input bit dn, input floorMaskT sw);
        @(posedge clk);
        update      <= 1'b1;
        hallFloor   <= FLOOR_W'(fl);
        hallUp      <= up;
        hallDown    <= dn;
        carSwitches <= sw;
        @(posedge clk);
        update   <= 1'b0;
        hallUp   <= 1'b0;
        hallDown <= 1'b0;
    endtask

    task automatic waitQuiet();
        int n;
        n = 0;
        @(posedge clk);
        while (!modelQuiet() && (n < 4 * TRIP_CYCLES))
        begin
            @(posedge clk);
            n++;
        end
        if (!modelQuiet())
        begin
            errors++;
            $display("Car still busy with calls after %0d cycles of waiting", n);
        end
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        update      = 1'b0;
        hallFloor   = '0;
        hallUp      = 1'b0;
        hallDown    = 1'b0;
        carSwitches = '0;
        lfsr        = 32'h4f79;
        checks      = 0;
        errors      = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Parked at floor 1 with the lamp idle
        @(negedge clk);
        check("resetSegments", segments, expSegments(RESET_FLOOR));
        check("resetDirection", direction, DIR_IDLE);

        // Car call to the top floor, lamp turns up three edges after the update
        pulseUpdate(0, 1'b0, 1'b0, 5'b10000);
        lat = 1;
        @(negedge clk);
        while ((direction != DIR_UP) && (lat < 10))
        begin
            @(negedge clk);
            lat++;
        end
        check("upLatency", lat, 3);
        waitQuiet();
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Down to the ground floor
        pulseUpdate(0, 1'b0, 1'b0, 5'b00001);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Hall down at 2 is passed on the way up to 4
        pulseUpdate(0, 1'b0, 1'b0, 5'b10000);
        pulseUpdate(2, 1'b0, 1'b1, 5'b10000);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Hall up at 3 stops a run from 2 to 4
        pulseUpdate(0, 1'b0, 1'b0, 5'b10000);
        pulseUpdate(3, 1'b1, 1'b0, 5'b10000);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Back to 2, then equal calls at 0 and 4
        pulseUpdate(2, 1'b0, 1'b1, 5'b00000);
        waitQuiet();
        pulseUpdate(0, 1'b0, 1'b0, 5'b10001);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Call at the parked floor opens the doors in place
        // A car call to 1 right after it waits for that dwell
        pulseUpdate(0, 1'b1, 1'b0, 5'b00000);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00010);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00000);
        waitQuiet();

        // Held switch calls once, again only after off and on
        pulseUpdate(0, 1'b0, 1'b0, 5'b00100);
        waitQuiet();
        // Away to 0 while switch 2 stays on
        pulseUpdate(0, 1'b0, 1'b0, 5'b00101);
        waitQuiet();
        // Both still on so the car stays at 0
        pulseUpdate(0, 1'b0, 1'b0, 5'b00101);
        waitQuiet();
        pulseUpdate(0, 1'b0, 1'b0, 5'b00001);
        pulseUpdate(0, 1'b0, 1'b0, 5'b00101);
        waitQuiet();

        // Random traffic, floors 5 to 7 included
        repeat (RAND_CYCLES)
        begin
            @(posedge clk);
            update    <= (randBits(2) == 0);
            hallFloor <= FLOOR_W'(randBits(3));
            hallUp    <= randBits(1) != 0;
            hallDown  <= randBits(1) != 0;
            if (randBits(3) == 0)
                carSwitches <= NUM_FLOORS'(randBits(5));
        end
        @(posedge clk);
        update <= 1'b0;
        waitQuiet();

        repeat (4) @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Upper bound on the run length
    initial
    begin
        #(STIM_CYCLES * TRIP_CYCLES * 2 * 4);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule
